// File: source/motion_pkg.sv
package motion_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int pwm_bits     = 11;  // duty value and pwm period counter
  localparam int cmd_bits     = 12;  // signed wheel command
  localparam int alpha_bits   = 13;  // signed angular acceleration
  localparam int omega_bits   = 16;  // signed wheel / platform speed
  localparam int heading_bits = 20;  // platform heading, wraps on full turn

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // duty count of a single pwm line, high cycles per window
  typedef logic        [pwm_bits-1:0]     duty_t;

  // wheel drive command, usable range -2045..+2045
  typedef logic signed [cmd_bits-1:0]     cmd_t;

  typedef logic signed [alpha_bits-1:0]   alpha_t;    // torque minus damping
  typedef logic signed [omega_bits-1:0]   omega_t;    // wheel or platform rate
  typedef logic signed [heading_bits-1:0] heading_t;  // one full turn = 2**20

  //////////////////////////////////////////////////
  // physics constants
  //////////////////////////////////////////////////

  // wheel speed never leaves +/- omega_max
  localparam int omega_max = 32700;

  // at or below this accel the wheel only sees friction
  localparam int fric_band = 32;

endpackage

// File: source/pwm_drive.sv
`timescale 1ns/1ps

module pwm_drive (
  input  logic             clk,
  input  logic             rst_n,
  input  motion_pkg::cmd_t lft_cmd,   // signed left wheel drive
  input  motion_pkg::cmd_t rght_cmd,  // signed right wheel drive
  output logic [3:0]       pwm        // 0 lft fwd, 1 lft rev, 2 rght fwd, 3 rght rev
);

  motion_pkg::duty_t per_cnt;      // free running period counter
  motion_pkg::duty_t phase;        // counter minus one
  motion_pkg::cmd_t  cmd [2];      // 0 left, 1 right
  motion_pkg::duty_t duty_q [4];   // latched duty, indexed like pwm

  assign cmd[0] = lft_cmd;
  assign cmd[1] = rght_cmd;

  // magnitude of a signed command in duty counts
  function automatic motion_pkg::duty_t cmd_mag(input motion_pkg::cmd_t c);
    motion_pkg::cmd_t neg;
    neg = -c;
    if (c[motion_pkg::cmd_bits-1]) begin
      return neg[motion_pkg::pwm_bits-1:0];
    end
    return c[motion_pkg::pwm_bits-1:0];
  endfunction

  //////////////////////////////////////////////////
  // period counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      per_cnt <= '0;
    end else begin
      per_cnt <= per_cnt + 1'b1;  // wraps every 2048 cycles
    end
  end

  //////////////////////////////////////////////////
  // duty latch, once per period
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int ch = 0; ch < 4; ch++) begin
        duty_q[ch] <= '0;
      end
    end else if (per_cnt == '0) begin  // period start, sample both commands
      for (int w = 0; w < 2; w++) begin
        // sign picks the line, the other one idles at zero duty
        duty_q[2*w]   <= cmd[w][motion_pkg::cmd_bits-1] ? '0 : cmd_mag(cmd[w]);
        duty_q[2*w+1] <= cmd[w][motion_pkg::cmd_bits-1] ? cmd_mag(cmd[w]) : '0;
      end
    end
  end

  // count 0 is spent loading the new duty, so high time runs over counts
  // 1..duty; phase wraps to all ones at count 0 which keeps the line low
  assign phase = per_cnt - 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm <= '0;
    end else begin
      for (int ch = 0; ch < 4; ch++) begin
        pwm[ch] <= (phase < duty_q[ch]);  // registered compare
      end
    end
  end

endmodule

// File: source/pwm_decode.sv
`timescale 1ns/1ps

module pwm_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pwm_in,  // one pwm line from the driver
  output motion_pkg::duty_t duty,    // high cycles of the last window
  output logic              vld      // one cycle pulse, new duty
);

  motion_pkg::duty_t win_cnt;   // window position, runs from reset
  motion_pkg::duty_t high_cnt;  // high cycles seen so far
  logic              win_end;   // last cycle of the window

  assign win_end = &win_cnt;

  //////////////////////////////////////////////////
  // window and high time counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;  // 2048 cycle window
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      high_cnt <= '0;
    end else if (win_end) begin
      high_cnt <= '0;  // last window cycle not counted
    end else if (pwm_in) begin
      high_cnt <= high_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // held result and valid strobe
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty <= '0;
      vld  <= 1'b0;
    end else begin
      vld <= win_end;  // lands with the new duty
      if (win_end) begin
        duty <= high_cnt;
      end
    end
  end

endmodule

// File: source/wheel_physics.sv
`timescale 1ns/1ps

module wheel_physics #(
  parameter motion_pkg::heading_t start_heading = '0  // heading out of reset
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 step,        // new duties present, integrate once
  input  motion_pkg::duty_t    duty_lf,     // left forward
  input  motion_pkg::duty_t    duty_lr,     // left reverse
  input  motion_pkg::duty_t    duty_rf,     // right forward
  input  motion_pkg::duty_t    duty_rr,     // right reverse
  output motion_pkg::omega_t   omega_lft,
  output motion_pkg::omega_t   omega_rght,
  output motion_pkg::heading_t heading,
  output logic                 upd          // outputs just changed
);

  // saturation limits of the acceleration type
  localparam int alpha_hi = 2 ** (motion_pkg::alpha_bits - 1) - 1;
  localparam int alpha_lo = -alpha_hi - 1;

  motion_pkg::alpha_t   alpha_l;       // left wheel accel this step
  motion_pkg::alpha_t   alpha_r;
  motion_pkg::omega_t   omega_l_nxt;   // speeds after this step
  motion_pkg::omega_t   omega_r_nxt;
  motion_pkg::omega_t   plat_rate;     // platform turn rate
  motion_pkg::heading_t heading_nxt;

  //////////////////////////////////////////////////
  // wheel acceleration
  //////////////////////////////////////////////////

  // torque is linear in duty difference, speed feeds back as damping
  function automatic motion_pkg::alpha_t wheel_alpha(
    input motion_pkg::duty_t  fwd,
    input motion_pkg::duty_t  rev,
    input motion_pkg::omega_t om
  );
    motion_pkg::omega_t torque;
    motion_pkg::omega_t wide;  // room for torque plus both damping terms

    torque = motion_pkg::omega_t'(fwd) - motion_pkg::omega_t'(rev);
    wide   = torque - (om >>> 4) - (om >>> 6);  // damping ~ 5/64 of speed
    if (wide > alpha_hi) begin
      return motion_pkg::alpha_t'(alpha_hi);
    end
    if (wide < alpha_lo) begin
      return motion_pkg::alpha_t'(alpha_lo);
    end
    return wide[motion_pkg::alpha_bits-1:0];
  endfunction

  //////////////////////////////////////////////////
  // wheel speed
  //////////////////////////////////////////////////

  // strong accel integrates, weak accel lets friction bleed speed off
  function automatic motion_pkg::omega_t wheel_omega(
    input motion_pkg::omega_t om,
    input motion_pkg::alpha_t acc
  );
    logic signed [motion_pkg::omega_bits:0] sum;  // one guard bit for the clamp

    if (acc > motion_pkg::fric_band || acc < -motion_pkg::fric_band) begin
      sum = om + (acc >>> 3);
      if (sum > motion_pkg::omega_max) begin
        return motion_pkg::omega_t'(motion_pkg::omega_max);
      end
      if (sum < -motion_pkg::omega_max) begin
        return motion_pkg::omega_t'(-motion_pkg::omega_max);
      end
      return sum[motion_pkg::omega_bits-1:0];
    end
    return om - (om >>> 6);  // friction, lose 1/64 per step
  endfunction

  //////////////////////////////////////////////////
  // one integration step, combinational
  //////////////////////////////////////////////////

  always_comb begin
    alpha_l     = wheel_alpha(duty_lf, duty_lr, omega_lft);
    alpha_r     = wheel_alpha(duty_rf, duty_rr, omega_rght);
    omega_l_nxt = wheel_omega(omega_lft, alpha_l);
    omega_r_nxt = wheel_omega(omega_rght, alpha_r);

    // halves keep the difference inside 16 bits
    plat_rate = (omega_r_nxt >>> 1) - (omega_l_nxt >>> 1);

    // gain ~ 1/128 + 1/256 - 1/4096 - 1/8192 - 1/16384, wraps at full turn
    heading_nxt = heading
                + (plat_rate >>> 7)
                + (plat_rate >>> 8)
                - (plat_rate >>> 12)
                - (plat_rate >>> 13)
                - (plat_rate >>> 14);
  end

  //////////////////////////////////////////////////
  // state, advances only on step
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      omega_lft  <= '0;
      omega_rght <= '0;
      heading    <= start_heading;
      upd        <= 1'b0;
    end else begin
      upd <= step;  // same edge as the new outputs
      if (step) begin
        omega_lft  <= omega_l_nxt;
        omega_rght <= omega_r_nxt;
        heading    <= heading_nxt;
      end
    end
  end

endmodule

// File: source/motion_top.sv
`timescale 1ns/1ps

module motion_top #(
  parameter motion_pkg::heading_t start_heading = '0  // handed to the physics block
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  motion_pkg::cmd_t     lft_cmd,     // held level, signed
  input  motion_pkg::cmd_t     rght_cmd,
  output motion_pkg::omega_t   omega_lft,
  output motion_pkg::omega_t   omega_rght,
  output motion_pkg::heading_t heading,
  output logic                 upd          // one cycle, new outputs
);

  logic [3:0]        pwm;       // 0 lft fwd, 1 lft rev, 2 rght fwd, 3 rght rev
  motion_pkg::duty_t duty [4];  // measured duty per line
  logic              step;      // window done, from channel 0

  //////////////////////////////////////////////////
  // motor driver model
  //////////////////////////////////////////////////

  pwm_drive u_drive (
    .clk      (clk),
    .rst_n    (rst_n),
    .lft_cmd  (lft_cmd),
    .rght_cmd (rght_cmd),
    .pwm      (pwm)
  );

  //////////////////////////////////////////////////
  // duty decoders
  //////////////////////////////////////////////////

  // all windows line up from reset, channel 0 paces the update
  for (genvar i = 0; i < 4; i++) begin : g_dec
    if (i == 0) begin : g_lead
      pwm_decode u_dec (
        .clk    (clk),
        .rst_n  (rst_n),
        .pwm_in (pwm[i]),
        .duty   (duty[i]),
        .vld    (step)
      );
    end else begin : g_follow
      pwm_decode u_dec (
        .clk    (clk),
        .rst_n  (rst_n),
        .pwm_in (pwm[i]),
        .duty   (duty[i]),
        .vld    ()       // same timing as channel 0
      );
    end
  end

  //////////////////////////////////////////////////
  // wheel and heading integration
  //////////////////////////////////////////////////

  wheel_physics #(
    .start_heading (start_heading)
  ) u_physics (
    .clk        (clk),
    .rst_n      (rst_n),
    .step       (step),
    .duty_lf    (duty[0]),
    .duty_lr    (duty[1]),
    .duty_rf    (duty[2]),
    .duty_rr    (duty[3]),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght),
    .heading    (heading),
    .upd        (upd)
  );

endmodule

// File: testbench/motion_chk.sv
`timescale 1ns/1ps

module motion_chk (
  input logic                 clk,
  input logic                 rst_n,
  input motion_pkg::omega_t   omega_lft,
  input motion_pkg::omega_t   omega_rght,
  input motion_pkg::heading_t heading,
  input logic                 upd
);

  int   gap;           // cycles since the last upd
  logic seen;          // first upd already passed
  int   fail_cnt = 0;  // failed assertions so far

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gap  <= 0;
      seen <= 1'b0;
    end else if (upd) begin
      gap  <= 0;
      seen <= 1'b1;
    end else begin
      gap <= gap + 1;
    end
  end

  //////////////////////////////////////////////////
  // update strobe timing
  //////////////////////////////////////////////////

  a_upd_pulse: assert property (@(posedge clk) disable iff (!rst_n) upd |=> !upd)
    else begin
      $error("upd held high for more than one cycle");
      fail_cnt++;
    end

  // one window of 2048 cycles between strobes
  a_upd_gap: assert property (@(posedge clk) disable iff (!rst_n) (upd && seen) |-> gap == 2047)
    else begin
      $error("upd spacing of %0d cycles instead of 2048", gap + 1);
      fail_cnt++;
    end

  //////////////////////////////////////////////////
  // output range and hold
  //////////////////////////////////////////////////

  a_omega_range: assert property (@(posedge clk) disable iff (!rst_n)
    int'(omega_lft) <= motion_pkg::omega_max && int'(omega_lft) >= -motion_pkg::omega_max &&
    int'(omega_rght) <= motion_pkg::omega_max && int'(omega_rght) >= -motion_pkg::omega_max)
    else begin
      $error("wheel speed outside the clamp");
      fail_cnt++;
    end

  // outputs only move on the edge that raises upd
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !upd |-> $stable(omega_lft) && $stable(omega_rght) && $stable(heading))
    else begin
      $error("outputs changed between upd pulses");
      fail_cnt++;
    end

endmodule

bind motion_top motion_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .omega_lft  (omega_lft),
  .omega_rght (omega_rght),
  .heading    (heading),
  .upd        (upd)
);

// File: testbench/motion_checker.sv
`timescale 1ns/1ps

module motion_checker #(
  parameter motion_pkg::heading_t start_heading = '0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  motion_pkg::cmd_t     lft_cmd,
  input  motion_pkg::cmd_t     rght_cmd,
  input  motion_pkg::omega_t   omega_lft,
  input  motion_pkg::omega_t   omega_rght,
  input  motion_pkg::heading_t heading,
  input  logic                 upd,
  input  int                   test_num,   // running test, 0 before the first
  output int                   err_cnt,
  output int                   upd_cnt
);

  int exp_l, exp_r, exp_h;   // model state after the last update
  int nxt_l, nxt_r, nxt_h;
  int cmd_l, cmd_r;          // command the driver latches for the next window
  bit fric_l, fric_r;
  int last_test, test_upd, test_err, test_fric;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // one wheel step, duty is the command magnitude on the line its sign picks
  function automatic int next_wheel_speed(input int om, input int cmd, output bit fric);
    int fwd;
    int rev;
    int acc;
    int nxt;
    fwd = (cmd > 0) ? cmd : 0;
    rev = (cmd < 0) ? -cmd : 0;
    acc = (fwd - rev) - (om >>> 4) - (om >>> 6);
    if (acc > 4095) acc = 4095;    // 13 bit signed limits
    if (acc < -4096) acc = -4096;
    fric = (acc <= motion_pkg::fric_band) && (acc >= -motion_pkg::fric_band);
    if (fric) begin
      return om - (om >>> 6);
    end
    nxt = om + (acc >>> 3);
    if (nxt > motion_pkg::omega_max) nxt = motion_pkg::omega_max;
    if (nxt < -motion_pkg::omega_max) nxt = -motion_pkg::omega_max;
    return nxt;
  endfunction

  function automatic int next_heading(input int h, input int oml, input int omr);
    int rate;
    int sum;
    rate = (omr >>> 1) - (oml >>> 1);
    sum  = h + (rate >>> 7) + (rate >>> 8) - (rate >>> 12) - (rate >>> 13) - (rate >>> 14);
    return (sum <<< 12) >>> 12;  // wrap into 20 bits, sign kept
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1:       return "idle";
      2:       return "straight";
      3:       return "pivot";
      4:       return "coast";
      5:       return "reverse";
      default: return "random";
    endcase
  endfunction

  task automatic compare(input string name, input int exp, input int got, input int bits);
    int mask;
    mask = (1 << bits) - 1;
    if (exp != got) begin
      $display("ERR %s expected %0h got %0h at update %0d", name, exp & mask, got & mask,
               upd_cnt + 1);
      err_cnt++;
      test_err++;
    end
  endtask

  //////////////////////////////////////////////////
  // compare at every update
  //////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_l = 0;
      exp_r = 0;
      exp_h = int'(start_heading);
      cmd_l = 0;            // commands held at zero through reset
      cmd_r = 0;
      err_cnt = 0;
      upd_cnt = 0;
      last_test = 0;
    end else begin
      if (upd) begin
        nxt_l = next_wheel_speed(exp_l, cmd_l, fric_l);
        nxt_r = next_wheel_speed(exp_r, cmd_r, fric_r);
        nxt_h = next_heading(exp_h, nxt_l, nxt_r);
        compare("omega_lft", nxt_l, int'(omega_lft), 16);
        compare("omega_rght", nxt_r, int'(omega_rght), 16);
        compare("heading", nxt_h, int'(heading), 20);
        exp_l = nxt_l;
        exp_r = nxt_r;
        exp_h = nxt_h;
        if (fric_l || fric_r) test_fric++;
        upd_cnt++;
        test_upd++;
        cmd_l = int'(lft_cmd);   // still the value held during this pulse
        cmd_r = int'(rght_cmd);
      end
      if (test_num != last_test) begin
        if (last_test == 4 && test_fric == 0) begin
          $display("coast test never reached the friction band");
          err_cnt++;
          test_err++;
        end
        if (last_test != 0) begin
          $display("test %0d %-8s %0d updates, %0d errors", last_test, test_name(last_test),
                   test_upd, test_err);
        end
        last_test = test_num;
        test_upd  = 0;
        test_err  = 0;
        test_fric = 0;
      end
    end
  end

endmodule

// File: testbench/motion_tb.sv
`timescale 1ns/1ps

module motion_tb;

  // close to the positive limit so the pivot wraps the heading
  localparam motion_pkg::heading_t start_heading = 20'h7ff00;

  localparam int n_idle     = 4;
  localparam int n_straight = 30;
  localparam int n_pivot    = 24;
  localparam int n_coast    = 400;   // long enough to reach the friction band
  localparam int n_reverse  = 30;
  localparam int n_random   = 40;
  localparam int n_total    = n_idle + n_straight + n_pivot + n_coast + n_reverse + n_random;
  localparam real wd_ns     = n_total * 2048 * 40.0 * 1.5;

  logic                 clk;
  logic                 rst_n;
  motion_pkg::cmd_t     lft_cmd;
  motion_pkg::cmd_t     rght_cmd;
  motion_pkg::omega_t   omega_lft;
  motion_pkg::omega_t   omega_rght;
  motion_pkg::heading_t heading;
  logic                 upd;
  int                   test_num;
  int                   seed;
  int                   tb_err;   // failures outside the value compare
  int                   chk_err;
  int                   chk_upd;
  int                   asrt_err; // failed bound assertions

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  motion_top #(
    .start_heading (start_heading)
  ) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .lft_cmd    (lft_cmd),
    .rght_cmd   (rght_cmd),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght),
    .heading    (heading),
    .upd        (upd)
  );

  motion_checker #(
    .start_heading (start_heading)
  ) check0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .lft_cmd    (lft_cmd),
    .rght_cmd   (rght_cmd),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght),
    .heading    (heading),
    .upd        (upd),
    .test_num   (test_num),
    .err_cnt    (chk_err),
    .upd_cnt    (chk_upd)
  );

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // returns on the edge that ends the upd pulse
  task automatic wait_for_upd();
    @(posedge clk);
    while (!upd) @(posedge clk);
  endtask

  task automatic drive_for(input int n, input int l, input int r);
    lft_cmd  <= motion_pkg::cmd_t'(l);
    rght_cmd <= motion_pkg::cmd_t'(r);
    repeat (n) wait_for_upd();
  endtask

  function automatic int random_cmd();
    return $random(seed) % 2046;  // -2045..2045
  endfunction

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    seed     = 72135;
    tb_err   = 0;
    rst_n    = 1'b0;
    lft_cmd  = '0;
    rght_cmd = '0;
    test_num = 0;
    repeat (3) @(posedge clk);
    rst_n    <= 1'b1;

    test_num <= 1;
    drive_for(n_idle, 0, 0);
    test_num <= 2;
    drive_for(n_straight, 2000, 2000);
    test_num <= 3;
    drive_for(n_pivot, -2000, 2000);  // right ahead, heading rises
    if (!heading[motion_pkg::heading_bits-1]) begin
      $display("pivot test: heading never wrapped past the 20-bit limit");
      tb_err++;
    end
    test_num <= 4;
    drive_for(n_coast, 0, 0);
    test_num <= 5;
    drive_for(n_reverse, -1500, -1800);
    if (omega_lft >= 0 || omega_rght >= 0) begin
      $display("reverse test: wheel speeds did not turn negative");
      tb_err++;
    end
    test_num <= 6;
    for (int i = 0; i < n_random; i++) begin
      drive_for(1, random_cmd(), random_cmd());
    end
    test_num <= 7;  // closes the last test report
    repeat (2) @(posedge clk);

    if (chk_upd != n_total) begin
      $display("only %0d of %0d planned updates were checked", chk_upd, n_total);
      tb_err++;
    end
    asrt_err = dut0.u_chk.fail_cnt;
    $display("summary: %0d updates, %0d compare errors, %0d assertion errors, %0d other errors",
             chk_upd, chk_err, asrt_err, tb_err);
    if (chk_err + asrt_err + tb_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog, planned updates with half again as margin
  initial begin
    #(wd_ns);
    $display("watchdog: upd stopped arriving after %0d updates", chk_upd);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: vlog.f
source/motion_pkg.sv
source/pwm_drive.sv
source/pwm_decode.sv
source/wheel_physics.sv
source/motion_top.sv
testbench/motion_chk.sv
testbench/motion_checker.sv
testbench/motion_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module motion_tb -f vlog.f -o motion_sim
	./obj_dir/motion_sim | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
